//--- verilog/autotest_pkg.sv
// ----------------------------------------
// autotest package
// record layout, field widths, signature,
// controller states and SD commands
// ----------------------------------------
package autotest_pkg;

  localparam int BYTE_W = 8;
  localparam int DATA_W = 128;
  localparam int ADDR_W = 32;
  localparam int IDX_W = 6;

  localparam int SIG_BYTES = 4;
  localparam int BLOCK_BYTES = 16;
  localparam int KEY_BYTES = 16;
  localparam logic [SIG_BYTES*BYTE_W-1:0] SIGNATURE = 32'hAABBCCDD;

  // byte offsets inside a record, fields stored msb first
  localparam int SIG_POS = 0;
  localparam int BLOCK_POS = SIG_POS + SIG_BYTES;
  localparam int KEY_POS = BLOCK_POS + BLOCK_BYTES;
  localparam int ENCDEC_POS = KEY_POS + KEY_BYTES;

  localparam int RECORD_BYTES = ENCDEC_POS + 1;
  localparam int RESULT_BYTES = DATA_W / BYTE_W;
  localparam int WRITE_BYTES = RECORD_BYTES + RESULT_BYTES;

  typedef enum logic [2:0] {
    S_IDLE, S_SD_RESET, S_READ_RECORD, S_CHECK_SIG,
    S_RUN_TEST, S_WRITE_RECORD, S_NEXT_BLOCK, S_HALT
  } ctrl_state_e;

  typedef enum logic [1:0] {
    SD_NONE, SD_RESET, SD_READ, SD_WRITE
  } sd_cmd_e;

endpackage

//--- verilog/sd_byte_sequencer.sv
// ----------------------------------------
// SD byte sequencer
// busy handshake with the SPI SD host for
// card reset, record read and write-back
// ----------------------------------------
module sd_byte_sequencer (
  input  logic                              clk,
  input  logic                              rst,
  input  autotest_pkg::sd_cmd_e             cmd_i,
  output logic                              done_o,
  input  logic                              spi_busy_i,
  input  logic [autotest_pkg::BYTE_W-1:0]   spi_data_out_i,
  output logic                              spi_rst_o,
  output logic                              spi_r_block_o,
  output logic                              spi_r_byte_o,
  output logic                              spi_w_block_o,
  output logic                              spi_w_byte_o,
  output logic [autotest_pkg::BYTE_W-1:0]   spi_data_in_o,
  output logic                              byte_wr_o,
  output logic [autotest_pkg::IDX_W-1:0]    byte_idx_o,
  output logic [autotest_pkg::BYTE_W-1:0]   byte_data_o,
  input  logic [autotest_pkg::BYTE_W-1:0]   wr_data_i
);
  import autotest_pkg::*;

  typedef enum logic [2:0] {
    SQ_IDLE, SQ_CMD, SQ_CMD_WAIT, SQ_LOAD, SQ_BYTE, SQ_BYTE_WAIT, SQ_DONE
  } seq_state_e;

  seq_state_e       state;
  logic [IDX_W-1:0] cnt;
  logic [IDX_W-1:0] last_idx;
  logic             is_read;
  logic             is_write;
  logic             active;

  assign is_read = cmd_i == SD_READ;
  assign is_write = cmd_i == SD_WRITE;
  assign last_idx = is_read ? IDX_W'(RECORD_BYTES - 1) : IDX_W'(WRITE_BYTES - 1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= SQ_IDLE;
      cnt <= '0;
    end
    else
    begin
      case (state)
        SQ_IDLE:
        begin
          cnt <= '0;
          if (cmd_i != SD_NONE)
            state <= SQ_CMD;
        end
        // strobe held until the host goes busy
        SQ_CMD:
          if (spi_busy_i)
            state <= SQ_CMD_WAIT;
        SQ_CMD_WAIT:
          if (!spi_busy_i)
            state <= (is_read || is_write) ? SQ_LOAD : SQ_DONE;
        SQ_LOAD:
          state <= SQ_BYTE;
        SQ_BYTE:
          if (spi_busy_i)
            state <= SQ_BYTE_WAIT;
        SQ_BYTE_WAIT:
          if (!spi_busy_i)
          begin
            if (cnt == last_idx)
              state <= SQ_DONE;
            else
            begin
              cnt <= cnt + 1'b1;
              state <= SQ_LOAD;
            end
          end
        default:
          state <= SQ_IDLE;
      endcase
    end
  end

  // write data follows the index, stable for the whole byte strobe
  always_ff @(posedge clk)
  begin
    if (state == SQ_LOAD)
      spi_data_in_o <= wr_data_i;
  end

  assign active = state inside {SQ_CMD, SQ_CMD_WAIT, SQ_LOAD, SQ_BYTE, SQ_BYTE_WAIT};

  assign spi_rst_o = (state == SQ_CMD) && (cmd_i == SD_RESET);
  assign spi_r_block_o = active && is_read;
  assign spi_w_block_o = active && is_write;
  assign spi_r_byte_o = (state == SQ_BYTE) && is_read;
  assign spi_w_byte_o = (state == SQ_BYTE) && is_write;

  // read byte valid when busy falls
  assign byte_wr_o = (state == SQ_BYTE_WAIT) && !spi_busy_i && is_read;
  assign byte_idx_o = cnt;
  assign byte_data_o = spi_data_out_i;
  assign done_o = state == SQ_DONE;

endmodule

//--- verilog/record_store.sv
// ----------------------------------------
// record store
// record bytes, signature compare, UUT
// operands, result latch, write-back mux
// ----------------------------------------
module record_store (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              clear_i,
  input  logic                              byte_wr_i,
  input  logic [autotest_pkg::IDX_W-1:0]    byte_idx_i,
  input  logic [autotest_pkg::BYTE_W-1:0]   byte_data_i,
  input  logic                              capture_i,
  input  logic [autotest_pkg::DATA_W-1:0]   result_i,
  output logic                              sig_ok_o,
  output logic [autotest_pkg::DATA_W-1:0]   block_o,
  output logic [autotest_pkg::DATA_W-1:0]   key_o,
  output logic                              encdec_o,
  output logic [autotest_pkg::BYTE_W-1:0]   rd_data_o
);
  import autotest_pkg::*;

  logic [BYTE_W-1:0]           rec [RECORD_BYTES];
  logic [DATA_W-1:0]           result;
  logic [SIG_BYTES*BYTE_W-1:0] sig;
  logic [IDX_W-1:0]            res_idx;

  always_ff @(posedge clk)
  begin
    if (rst || clear_i)
    begin
      for (int i = 0; i < RECORD_BYTES; i++)
        rec[i] <= '0;
    end
    else if (byte_wr_i && (byte_idx_i < IDX_W'(RECORD_BYTES)))
      rec[byte_idx_i] <= byte_data_i;
  end

  always_ff @(posedge clk)
  begin
    if (capture_i)
      result <= result_i;
  end

  // first byte of each field is the most significant
  always_comb
  begin
    for (int i = 0; i < SIG_BYTES; i++)
      sig[BYTE_W*(SIG_BYTES-1-i) +: BYTE_W] = rec[SIG_POS+i];
    for (int i = 0; i < BLOCK_BYTES; i++)
      block_o[BYTE_W*(BLOCK_BYTES-1-i) +: BYTE_W] = rec[BLOCK_POS+i];
    for (int i = 0; i < KEY_BYTES; i++)
      key_o[BYTE_W*(KEY_BYTES-1-i) +: BYTE_W] = rec[KEY_POS+i];
  end

  assign encdec_o = rec[ENCDEC_POS][0];
  assign sig_ok_o = sig == SIGNATURE;

  // result goes out after the record, lsb first
  assign res_idx = byte_idx_i - IDX_W'(RECORD_BYTES);

  always_comb
  begin
    if (byte_idx_i < IDX_W'(RECORD_BYTES))
      rd_data_o = rec[byte_idx_i];
    else if (res_idx < IDX_W'(RESULT_BYTES))
      rd_data_o = result[BYTE_W*res_idx +: BYTE_W];
    else
      rd_data_o = '0;
  end

endmodule

//--- verilog/autotest_ctrl.sv
// ----------------------------------------
// autotest controller
// per-block test FSM, UUT reset, timeout
// timer and SD block address counter
// ----------------------------------------
module autotest_ctrl #(
  parameter logic [31:0]                     TIMEOUT_CYCLES = 32'h6E00000,
  parameter logic [autotest_pkg::ADDR_W-1:0] BASE_BLOCK = 32'h00100000
) (
  input  logic                              clk,
  input  logic                              rst,
  output autotest_pkg::sd_cmd_e             cmd_o,
  input  logic                              seq_done_i,
  output logic                              clear_o,
  output logic                              capture_o,
  input  logic                              sig_ok_i,
  input  logic                              uut_done_i,
  output logic                              uut_rst_o,
  output logic [autotest_pkg::ADDR_W-1:0]   block_addr_o,
  output logic                              halted_o
);
  import autotest_pkg::*;

  ctrl_state_e       state;
  logic [31:0]       timer;
  logic [ADDR_W-1:0] block_addr;
  logic              test_end;

  // done from the UUT or timeout, whichever comes first
  assign test_end = (state == S_RUN_TEST) &&
                    (uut_done_i || (timer == TIMEOUT_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= S_IDLE;
      timer <= '0;
      block_addr <= BASE_BLOCK;
    end
    else
    begin
      timer <= (state == S_RUN_TEST) ? timer + 1'b1 : '0;
      case (state)
        S_IDLE:
          state <= S_SD_RESET;
        S_SD_RESET:
          if (seq_done_i)
            state <= S_READ_RECORD;
        S_READ_RECORD:
          if (seq_done_i)
            state <= S_CHECK_SIG;
        S_CHECK_SIG:
          state <= sig_ok_i ? S_RUN_TEST : S_HALT;
        S_RUN_TEST:
          if (test_end)
            state <= S_WRITE_RECORD;
        S_WRITE_RECORD:
          if (seq_done_i)
            state <= S_NEXT_BLOCK;
        S_NEXT_BLOCK:
        begin
          block_addr <= block_addr + 1'b1;
          state <= S_SD_RESET;
        end
        // bad signature, wait for rst
        S_HALT:
          state <= S_HALT;
        default:
          state <= S_IDLE;
      endcase
    end
  end

  always_comb
  begin
    case (state)
      S_SD_RESET:     cmd_o = SD_RESET;
      S_READ_RECORD:  cmd_o = SD_READ;
      S_WRITE_RECORD: cmd_o = SD_WRITE;
      default:        cmd_o = SD_NONE;
    endcase
  end

  assign clear_o = state == S_IDLE;
  assign capture_o = test_end;
  assign uut_rst_o = state != S_RUN_TEST;
  assign halted_o = state == S_HALT;
  assign block_addr_o = block_addr;

endmodule

//--- verilog/sd_autotest_top.sv
// ----------------------------------------
// SD autotest top level
// controller, SD byte sequencer and record
// store between the SD host and the UUT
// ----------------------------------------
module sd_autotest_top #(
  parameter logic [31:0]                     TIMEOUT_CYCLES = 32'h6E00000,
  parameter logic [autotest_pkg::ADDR_W-1:0] BASE_BLOCK = 32'h00100000
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              spi_busy_i,
  input  logic [autotest_pkg::BYTE_W-1:0]   spi_data_out_i,
  output logic                              spi_rst_o,
  output logic                              spi_r_block_o,
  output logic                              spi_r_byte_o,
  output logic                              spi_w_block_o,
  output logic                              spi_w_byte_o,
  output logic [autotest_pkg::BYTE_W-1:0]   spi_data_in_o,
  output logic [autotest_pkg::ADDR_W-1:0]   spi_block_addr_o,
  output logic                              uut_rst_o,
  output logic [autotest_pkg::DATA_W-1:0]   uut_block_o,
  output logic [autotest_pkg::DATA_W-1:0]   uut_key_o,
  output logic                              uut_encdec_o,
  input  logic [autotest_pkg::DATA_W-1:0]   uut_block_i,
  input  logic                              uut_done_i,
  output logic                              halted_o
);
  import autotest_pkg::*;

  sd_cmd_e          cmd;
  logic             seq_done;
  logic             clear;
  logic             capture;
  logic             sig_ok;
  logic             byte_wr;
  logic [IDX_W-1:0] byte_idx;
  logic [BYTE_W-1:0] byte_data;
  logic [BYTE_W-1:0] wr_data;

  autotest_ctrl #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .BASE_BLOCK(BASE_BLOCK)
  ) ctrl_i (
    .clk(clk),
    .rst(rst),
    .cmd_o(cmd),
    .seq_done_i(seq_done),
    .clear_o(clear),
    .capture_o(capture),
    .sig_ok_i(sig_ok),
    .uut_done_i(uut_done_i),
    .uut_rst_o(uut_rst_o),
    .block_addr_o(spi_block_addr_o),
    .halted_o(halted_o)
  );

  sd_byte_sequencer seq_i (
    .clk(clk),
    .rst(rst),
    .cmd_i(cmd),
    .done_o(seq_done),
    .spi_busy_i(spi_busy_i),
    .spi_data_out_i(spi_data_out_i),
    .spi_rst_o(spi_rst_o),
    .spi_r_block_o(spi_r_block_o),
    .spi_r_byte_o(spi_r_byte_o),
    .spi_w_block_o(spi_w_block_o),
    .spi_w_byte_o(spi_w_byte_o),
    .spi_data_in_o(spi_data_in_o),
    .byte_wr_o(byte_wr),
    .byte_idx_o(byte_idx),
    .byte_data_o(byte_data),
    .wr_data_i(wr_data)
  );

  record_store store_i (
    .clk(clk),
    .rst(rst),
    .clear_i(clear),
    .byte_wr_i(byte_wr),
    .byte_idx_i(byte_idx),
    .byte_data_i(byte_data),
    .capture_i(capture),
    .result_i(uut_block_i),
    .sig_ok_o(sig_ok),
    .block_o(uut_block_o),
    .key_o(uut_key_o),
    .encdec_o(uut_encdec_o),
    .rd_data_o(wr_data)
  );

endmodule

//--- tb/tb_clk_gen.sv
// ----------------------------------------
// testbench clock and reset
// ----------------------------------------
module tb_clk_gen #(
  parameter int PERIOD = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // released just after an edge, like the other inputs
  initial
  begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

//--- tb/tb_sd_autotest_sva.sv
// ----------------------------------------
// SD autotest assertions
// strobe exclusion, UUT reset while the
// SD host is busy, halt, UUT run length
// ----------------------------------------
module tb_sd_autotest_sva #(
  parameter logic [31:0] TIMEOUT_CYCLES = 32'd64
) (
  input logic clk,
  input logic rst,
  input logic spi_rst_i,
  input logic spi_r_block_i,
  input logic spi_r_byte_i,
  input logic spi_w_block_i,
  input logic spi_w_byte_i,
  input logic uut_rst_i,
  input logic halted_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;
  logic [31:0] low_cnt;
  logic        rd_strobe;
  logic        wr_strobe;
  logic        any_strobe;

  assign rd_strobe = spi_r_block_i || spi_r_byte_i;
  assign wr_strobe = spi_w_block_i || spi_w_byte_i;
  assign any_strobe = rd_strobe || wr_strobe || spi_rst_i;

  // cycles the UUT has been out of reset
  always_ff @(posedge clk)
  begin
    if (rst || uut_rst_i)
      low_cnt <= '0;
    else
      low_cnt <= low_cnt + 1'b1;
  end

  rw_excl: assert property (@(posedge clk) disable iff (rst) !(rd_strobe && wr_strobe))
  else
  begin
    $error("read and write strobes high together");
    fail_cnt++;
  end

  uut_held: assert property (@(posedge clk) disable iff (rst) any_strobe |-> uut_rst_i)
  else
  begin
    $error("SD strobe while the UUT is out of reset");
    fail_cnt++;
  end

  halt_quiet: assert property (@(posedge clk) disable iff (rst) halted_i |-> !any_strobe)
  else
  begin
    $error("SD strobe after halt");
    fail_cnt++;
  end

  run_len: assert property (@(posedge clk) disable iff (rst) low_cnt <= TIMEOUT_CYCLES + 1)
  else
  begin
    $error("UUT out of reset longer than the timeout");
    fail_cnt++;
  end

endmodule

//--- tb/tb_sd_autotest.sv
// ----------------------------------------
// SD autotest testbench
// SD host and card model, UUT model,
// record checks, report and watchdog
// ----------------------------------------
module tb_sd_autotest;
  timeunit 1ns;
  timeprecision 1ps;
  import autotest_pkg::*;

  localparam logic [31:0] TIMEOUT_CYCLES = 32'd64;
  localparam logic [31:0] BASE_BLOCK = 32'h00100000;
  localparam logic [31:0] SEED = 32'hea25;
  localparam int NUM_BLOCKS = 4;
  localparam int TIMEOUT_BLK = 1;
  localparam int BAD_BLK = 3;
  localparam int CYCLE_LIMIT = NUM_BLOCKS * (RECORD_BYTES + WRITE_BYTES + 2) * 10 +
                               NUM_BLOCKS * int'(TIMEOUT_CYCLES);
  // field offsets in a record, msb first
  localparam int BLK_AT = 4;
  localparam int KEY_AT = 20;
  localparam int FLAG_AT = 36;

  logic         clk;
  logic         rst;
  logic         spi_busy;
  logic [7:0]   spi_data_out;
  logic         spi_rst;
  logic         spi_r_block;
  logic         spi_r_byte;
  logic         spi_w_block;
  logic         spi_w_byte;
  logic [7:0]   spi_data_in;
  logic [31:0]  spi_block_addr;
  logic         uut_rst;
  logic [127:0] uut_block;
  logic [127:0] uut_key;
  logic         uut_encdec;
  logic [127:0] uut_result;
  logic         uut_done;
  logic         halted;

  logic [7:0]   card [NUM_BLOCKS][RECORD_BYTES];
  logic [7:0]   written [NUM_BLOCKS][WRITE_BYTES];
  int           wr_cnt [NUM_BLOCKS];
  logic [127:0] shown [NUM_BLOCKS];
  logic [31:0]  host_seed;
  int           cur_blk;
  int           reads;
  int           blocks_checked;
  int           err_mark;
  int           main_errs;
  int           host_errs;
  int           uut_errs;
  int           cycles;

  tb_clk_gen #(.PERIOD(40), .RESET_CYCLES(2)) clk_gen_i (.clk_o(clk), .rst_o(rst));

  sd_autotest_top #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .BASE_BLOCK(BASE_BLOCK)
  ) dut_i (
    .clk(clk),
    .rst(rst),
    .spi_busy_i(spi_busy),
    .spi_data_out_i(spi_data_out),
    .spi_rst_o(spi_rst),
    .spi_r_block_o(spi_r_block),
    .spi_r_byte_o(spi_r_byte),
    .spi_w_block_o(spi_w_block),
    .spi_w_byte_o(spi_w_byte),
    .spi_data_in_o(spi_data_in),
    .spi_block_addr_o(spi_block_addr),
    .uut_rst_o(uut_rst),
    .uut_block_o(uut_block),
    .uut_key_o(uut_key),
    .uut_encdec_o(uut_encdec),
    .uut_block_i(uut_result),
    .uut_done_i(uut_done),
    .halted_o(halted)
  );

  bind sd_autotest_top tb_sd_autotest_sva #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) sva_i (
    .clk(clk),
    .rst(rst),
    .spi_rst_i(spi_rst_o),
    .spi_r_block_i(spi_r_block_o),
    .spi_r_byte_i(spi_r_byte_o),
    .spi_w_block_i(spi_w_block_o),
    .spi_w_byte_i(spi_w_byte_o),
    .uut_rst_i(uut_rst_o),
    .halted_i(halted_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [127:0] field(input int b, input int pos);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < 16; i++)
      v = {v[119:0], card[b][pos+i]};
    return v;
  endfunction

  // UUT model: block xor key, inverted for decrypt
  function automatic logic [127:0] cipher(input int b);
    logic [127:0] r;
    r = field(b, BLK_AT) ^ field(b, KEY_AT);
    return card[b][FLAG_AT][0] ? ~r : r;
  endfunction

  function automatic bit same(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
    if (got !== exp)
      $display("Mismatch %s: got %0h expected %0h", name, got, exp);
    return got === exp;
  endfunction

  function automatic int err_total();
    return main_errs + host_errs + uut_errs;
  endfunction

  // busy for 1 to 4 cycles, data valid once busy falls
  task automatic answer(input logic [7:0] data);
    int n;
    host_seed = xorshift(host_seed);
    n = 1 + int'(host_seed % 32'd4);
    spi_busy = 1'b1;
    repeat (n) @(posedge clk);
    #2;
    spi_busy = 1'b0;
    spi_data_out = data;
  endtask

  task automatic check_writeback(input int b);
    logic [127:0] res;
    res = (b == TIMEOUT_BLK) ? shown[b] : cipher(b);
    assert (wr_cnt[b] == WRITE_BYTES)
    else
    begin
      $display("block %0d: %0d bytes written back, not %0d", b, wr_cnt[b], WRITE_BYTES);
      host_errs++;
    end
    for (int i = 0; i < RECORD_BYTES; i++)
      assert (same($sformatf("spi_data_in_o byte %0d", i), 128'(written[b][i]),
                   128'(card[b][i])))
      else
        host_errs++;
    for (int i = 0; i < RESULT_BYTES; i++)
      assert (same($sformatf("spi_data_in_o byte %0d", RECORD_BYTES + i),
                   128'(written[b][RECORD_BYTES+i]), 128'(res[8*i +: 8])))
      else
        host_errs++;
    blocks_checked++;
    $display("block %0d: %s", b, (err_total() == err_mark) ? "ok" : "failed");
  endtask

  initial
  begin : sd_host
    int  rd_idx;
    bit  r_open;
    bit  w_open;
    host_seed = SEED ^ 32'h00005a5a;
    spi_busy = 1'b0;
    spi_data_out = '0;
    rd_idx = 0;
    r_open = 1'b0;
    w_open = 1'b0;
    reads = 0;
    cur_blk = 0;
    blocks_checked = 0;
    err_mark = 0;
    host_errs = 0;
    for (int b = 0; b < NUM_BLOCKS; b++)
      wr_cnt[b] = 0;
    forever
    begin
      @(posedge clk);
      #2;
      if (w_open && !spi_w_block)
      begin
        w_open = 1'b0;
        check_writeback(cur_blk);
      end
      if (!spi_r_block)
        r_open = 1'b0;
      if (spi_rst)
        answer(8'h00);
      else if (spi_r_block && !r_open)
      begin
        r_open = 1'b1;
        rd_idx = 0;
        err_mark = err_total();
        assert (same("spi_block_addr_o", 128'(spi_block_addr), 128'(BASE_BLOCK + 32'(reads))))
        else
          host_errs++;
        cur_blk = int'(spi_block_addr - BASE_BLOCK);
        reads++;
        answer(8'h00);
      end
      else if (spi_r_byte)
      begin
        answer(card[cur_blk][rd_idx]);
        rd_idx++;
      end
      else if (spi_w_block && !w_open)
      begin
        w_open = 1'b1;
        answer(8'h00);
      end
      else if (spi_w_byte)
      begin
        written[cur_blk][wr_cnt[cur_blk]] = spi_data_in;
        wr_cnt[cur_blk]++;
        answer(8'h00);
      end
    end
  end

  initial
  begin : uut_model
    logic [31:0] seed;
    int          low_cnt;
    int          delay;
    seed = SEED ^ 32'h0000ffff;
    low_cnt = 0;
    delay = 0;
    uut_errs = 0;
    uut_done = 1'b0;
    uut_result = '0;
    forever
    begin
      @(posedge clk);
      #2;
      if (uut_rst)
      begin
        if (low_cnt > 0 && cur_blk == TIMEOUT_BLK)
        begin
          assert (low_cnt >= int'(TIMEOUT_CYCLES))
          else
          begin
            $display("timeout test: uut_rst_o low for only %0d cycles", low_cnt);
            uut_errs++;
          end
        end
        else if (low_cnt > 0)
        begin
          assert (low_cnt == delay)
          else
          begin
            $display("uut_rst_o low %0d cycles, done came after %0d", low_cnt, delay);
            uut_errs++;
          end
        end
        low_cnt = 0;
        uut_done = 1'b0;
      end
      else
      begin
        if (low_cnt == 0)
        begin
          seed = xorshift(seed);
          delay = 2 + int'(seed % 32'd19);
        end
        low_cnt++;
        assert (same("uut_block_o", uut_block, field(cur_blk, BLK_AT)))
        else
          uut_errs++;
        assert (same("uut_key_o", uut_key, field(cur_blk, KEY_AT)))
        else
          uut_errs++;
        assert (same("uut_encdec_o", 128'(uut_encdec), 128'(card[cur_blk][FLAG_AT][0])))
        else
          uut_errs++;
        seed = xorshift(seed);
        // the timeout block never answers, only noise on the result bus
        if (cur_blk != TIMEOUT_BLK && low_cnt == delay)
        begin
          uut_done = 1'b1;
          uut_result = cipher(cur_blk);
        end
        else
          uut_result = {4{seed}};
        shown[cur_blk] = uut_result;
      end
    end
  end

  initial
  begin : main
    logic [31:0] seed;
    logic [31:0] sig;
    int          mark;
    seed = SEED;
    sig = 32'hAABBCCDD;
    main_errs = 0;
    for (int b = 0; b < NUM_BLOCKS; b++)
    begin
      for (int i = 0; i < RECORD_BYTES; i++)
      begin
        seed = xorshift(seed);
        card[b][i] = seed[7:0];
      end
      for (int i = 0; i < 4; i++)
        card[b][i] = sig[31-8*i -: 8];
      card[b][FLAG_AT][0] = (b == 0);
    end
    card[BAD_BLK][3] = 8'hDC;

    @(posedge clk);
    #2;
    assert (same("spi strobes", 128'({spi_rst, spi_r_block, spi_r_byte, spi_w_block,
                 spi_w_byte}), 128'(0)))
    else
      main_errs++;
    assert (same("uut_rst_o", 128'(uut_rst), 128'(1)))
    else
      main_errs++;
    assert (same("halted_o", 128'(halted), 128'(0)))
    else
      main_errs++;
    $display("reset: %s", (main_errs == 0) ? "ok" : "failed");

    wait (halted === 1'b1);
    mark = err_total();
    repeat (20) @(posedge clk);
    #2;
    assert (same("halted_o", 128'(halted), 128'(1)))
    else
      main_errs++;
    assert (reads == NUM_BLOCKS)
    else
    begin
      $display("%0d records read instead of %0d", reads, NUM_BLOCKS);
      main_errs++;
    end
    assert (wr_cnt[BAD_BLK] == 0 && blocks_checked == NUM_BLOCKS - 1)
    else
    begin
      $display("write-back count wrong around the bad-signature block");
      main_errs++;
    end
    $display("halt: %s", (err_total() == mark) ? "ok" : "failed");

    $display("tests %0d, failed checks %0d, assertion failures %0d",
             2 + blocks_checked, err_total(), dut_i.sva_i.fail_cnt);
    if (err_total() == 0 && dut_i.sva_i.fail_cnt == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("run did not halt within %0d cycles", CYCLE_LIMIT);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- list.f
verilog/autotest_pkg.sv
verilog/sd_byte_sequencer.sv
verilog/record_store.sv
verilog/autotest_ctrl.sv
verilog/sd_autotest_top.sv
tb/tb_clk_gen.sv
tb/tb_sd_autotest_sva.sv
tb/tb_sd_autotest.sv

//--- run.sh
#!/bin/sh
# build and run the SD autotest testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_sd_autotest -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sd_autotest +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
